// File: include/tensor_settings.svh
`ifndef TENSOR_SETTINGS_SVH
`define TENSOR_SETTINGS_SVH

// lanes per operand bus, one octet
`define TC_LANES 8

// warps tracked by the pair buffers and metadata queues
`define TC_NUM_WARPS 4
`define TC_WID_W 2

// element, destination register and tag widths
`define TC_DATA_W 32
`define TC_RD_W 5
`define TC_TAG_W 8

// metadata entries per warp and result tiles held before writeback
`define TC_META_DEPTH 4
`define TC_RESULT_DEPTH 2

// stages of the multiply-accumulate pipe, must be at least 2
`define TC_DPU_LATENCY 3

`endif

// File: hdl/tensor_pkg.sv
`include "tensor_settings.svh"

package tensor_pkg;

    // one operand register across the octet
    typedef logic [`TC_LANES-1:0][`TC_DATA_W-1:0] tc_lanes_t;

    typedef struct packed {
        logic [`TC_WID_W-1:0] wid;
        logic [1:0]           step;
        logic                 last_in_pair;
        logic [`TC_RD_W-1:0]  rd;
        logic [`TC_TAG_W-1:0] tag;
        tc_lanes_t            a;
        tc_lanes_t            b;
        tc_lanes_t            c;
    } tc_issue_t;

    // what the writeback needs back from each operation
    typedef struct packed {
        logic [`TC_RD_W-1:0]  rd;
        logic [`TC_TAG_W-1:0] tag;
    } tc_meta_t;

    // a column of A, a row of B and two rows of C
    typedef struct packed {
        logic [3:0][`TC_DATA_W-1:0] a;
        logic [3:0][`TC_DATA_W-1:0] b;
        tc_lanes_t                  c;
    } tc_half_t;

    // a is indexed [m][k], b is indexed [k][n], c is indexed [m][n]
    typedef struct packed {
        logic [`TC_WID_W-1:0]            wid;
        logic [3:0][1:0][`TC_DATA_W-1:0] a;
        logic [1:0][3:0][`TC_DATA_W-1:0] b;
        logic [3:0][3:0][`TC_DATA_W-1:0] c;
    } tc_tile_op_t;

    typedef struct packed {
        logic [`TC_WID_W-1:0]            wid;
        logic [3:0][3:0][`TC_DATA_W-1:0] d;
    } tc_tile_res_t;

    typedef struct packed {
        logic [`TC_WID_W-1:0] wid;
        logic [`TC_RD_W-1:0]  rd;
        logic [`TC_TAG_W-1:0] tag;
        logic                 last_beat;
        tc_lanes_t            data;
    } tc_commit_t;

endpackage

// File: hdl/tensor_fifo.sv
`timescale 1ns/100ps

module tensor_fifo #(
    parameter type payload_t = logic,
    parameter int depth = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t data_in,
    input  logic     pop,
    output payload_t data_out,
    output logic     empty,
    output logic     full
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // storage carries no reset, only the pointers do
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(depth));

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// File: hdl/tensor_operand_decode.sv
`timescale 1ns/100ps
`include "tensor_settings.svh"

module tensor_operand_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue_valid,
    output logic                       issue_ready,
    input  tensor_pkg::tc_issue_t      issue_data,
    input  logic [`TC_NUM_WARPS-1:0]   meta_space,
    output logic                       meta_push,
    output logic [`TC_WID_W-1:0]       meta_wid,
    output tensor_pkg::tc_meta_t       meta_data,
    output logic                       op_valid,
    input  logic                       op_ready,
    output tensor_pkg::tc_tile_op_t    op
);
    import tensor_pkg::*;

    tc_half_t                  half_buf [`TC_NUM_WARPS];
    logic [`TC_NUM_WARPS-1:0] pending;
    tc_half_t                  live_half;
    tc_half_t                  prev_half;
    logic                      accept;

    // step bit 0 picks the A column, step bit 1 picks the B row
    function automatic tc_half_t select_half(input tc_issue_t data);
        tc_half_t h;
        for (int m = 0; m < 4; m++) begin
            h.a[m] = data.a[4 * (m / 2) + 2 * data.step[0] + (m % 2)];
            h.b[m] = data.b[4 * data.step[1] + m];
        end
        h.c = data.c;
        return h;
    endfunction

    assign live_half = select_half(issue_data);

    // a second operation without a buffered first sees zeroes
    assign prev_half = pending[issue_data.wid] ? half_buf[issue_data.wid] : '0;

    // first operations never wait on the pipe
    assign issue_ready = meta_space[issue_data.wid]
                         && (!issue_data.last_in_pair || op_ready);
    assign accept      = issue_valid && issue_ready;

    assign op_valid = issue_valid && issue_data.last_in_pair && meta_space[issue_data.wid];

    always_comb begin
        op.wid = issue_data.wid;
        for (int m = 0; m < 4; m++) begin
            op.a[m][0] = prev_half.a[m];
            op.a[m][1] = live_half.a[m];
        end
        op.b[0]   = prev_half.b;
        op.b[1]   = live_half.b;
        // rows 0-1 of C come from the first operation, rows 2-3 from the second
        op.c[1:0] = prev_half.c;
        op.c[3:2] = live_half.c;
    end

    always_ff @(posedge clk) begin
        if (accept && !issue_data.last_in_pair) begin
            half_buf[issue_data.wid] <= live_half;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else if (accept) begin
            pending[issue_data.wid] <= !issue_data.last_in_pair;
        end
    end

    assign meta_push     = accept;
    assign meta_wid      = issue_data.wid;
    assign meta_data.rd  = issue_data.rd;
    assign meta_data.tag = issue_data.tag;

    // a tile the pipe has not taken stays on offer unchanged
    a_op_held: assert property (@(posedge clk) disable iff (reset)
        op_valid && !op_ready |=> op_valid && $stable(op));

endmodule

// File: hdl/tensor_dpu.sv
`timescale 1ns/100ps
`include "tensor_settings.svh"

module tensor_dpu (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     op_valid,
    output logic                     op_ready,
    input  tensor_pkg::tc_tile_op_t  op,
    output logic                     res_valid,
    input  logic                     res_ready,
    output tensor_pkg::tc_tile_res_t res
);
    import tensor_pkg::*;

    localparam int lat = `TC_DPU_LATENCY;

    logic [lat-1:0]                        valid_q;
    logic [1:0][3:0][3:0][`TC_DATA_W-1:0]  prod_q;
    logic [3:0][3:0][`TC_DATA_W-1:0]       c_q;
    logic [`TC_WID_W-1:0]                  wid_q;
    tc_tile_res_t                          res_q [1:lat-1];
    logic                                  advance;

    // whole pipe holds while the last stage waits
    assign advance = !(valid_q[lat-1] && !res_ready);
    assign op_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[lat-2:0], op_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            // stage 0: all 32 products, modulo 2^32
            for (int k = 0; k < 2; k++) begin
                for (int m = 0; m < 4; m++) begin
                    for (int n = 0; n < 4; n++) begin
                        prod_q[k][m][n] <= op.a[m][k] * op.b[k][n];
                    end
                end
            end
            c_q   <= op.c;
            wid_q <= op.wid;

            // stage 1: accumulate both k terms onto C
            res_q[1].wid <= wid_q;
            for (int m = 0; m < 4; m++) begin
                for (int n = 0; n < 4; n++) begin
                    res_q[1].d[m][n] <= prod_q[0][m][n] + prod_q[1][m][n] + c_q[m][n];
                end
            end

            // remaining stages only delay the tile
            for (int i = 2; i < lat; i++) begin
                res_q[i] <= res_q[i-1];
            end
        end
    end

    assign res_valid = valid_q[lat-1];
    assign res       = res_q[lat-1];

    a_res_stable: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

// File: hdl/tensor_commit.sv
`timescale 1ns/100ps
`include "tensor_settings.svh"

module tensor_commit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     meta_push,
    input  logic [`TC_WID_W-1:0]     meta_wid,
    input  tensor_pkg::tc_meta_t     meta_data,
    output logic [`TC_NUM_WARPS-1:0] meta_space,
    input  logic                     res_valid,
    output logic                     res_ready,
    input  tensor_pkg::tc_tile_res_t res,
    output logic                     commit_valid,
    input  logic                     commit_ready,
    output tensor_pkg::tc_commit_t   commit_data
);
    import tensor_pkg::*;

    tc_meta_t                 meta_head [`TC_NUM_WARPS];
    logic [`TC_NUM_WARPS-1:0] meta_empty;
    logic [`TC_NUM_WARPS-1:0] meta_full;
    tc_tile_res_t             tile;
    logic                     tile_empty;
    logic                     tile_full;
    logic                     commit_fire;
    logic                     beat;

    assign commit_fire = commit_valid && commit_ready;

    // one queue per warp so that a pair's two entries stay adjacent
    // even when warps interleave their issue
    for (genvar w = 0; w < `TC_NUM_WARPS; w++) begin : g_meta
        tensor_fifo #(
            .payload_t (tc_meta_t),
            .depth     (`TC_META_DEPTH)
        ) i_meta_fifo (
            .clk      (clk),
            .reset    (reset),
            .push     (meta_push && (meta_wid == `TC_WID_W'(w))),
            .data_in  (meta_data),
            .pop      (commit_fire && (tile.wid == `TC_WID_W'(w))),
            .data_out (meta_head[w]),
            .empty    (meta_empty[w]),
            .full     (meta_full[w])
        );
    end

    assign meta_space = ~meta_full;

    tensor_fifo #(
        .payload_t (tc_tile_res_t),
        .depth     (`TC_RESULT_DEPTH)
    ) i_tile_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (res_valid && res_ready),
        .data_in  (res),
        .pop      (commit_fire && beat),
        .data_out (tile),
        .empty    (tile_empty),
        .full     (tile_full)
    );

    assign res_ready    = !tile_full;
    assign commit_valid = !tile_empty;

    // beat 0 writes rows 0-1, beat 1 writes rows 2-3
    always_ff @(posedge clk) begin
        if (reset) begin
            beat <= 1'b0;
        end else if (commit_fire) begin
            beat <= !beat;
        end
    end

    always_comb begin
        commit_data.wid       = tile.wid;
        commit_data.rd        = meta_head[tile.wid].rd;
        commit_data.tag       = meta_head[tile.wid].tag;
        commit_data.last_beat = beat;
        commit_data.data      = beat ? tile.d[3:2] : tile.d[1:0];
    end

    // metadata for a tile was pushed at issue, long before it reaches here
    a_meta_present: assert property (@(posedge clk) disable iff (reset)
        commit_fire |-> !meta_empty[tile.wid]);

endmodule

// File: hdl/tensor_octet_core.sv
`timescale 1ns/100ps
`include "tensor_settings.svh"

module tensor_octet_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    output logic                   issue_ready,
    input  tensor_pkg::tc_issue_t  issue_data,
    output logic                   commit_valid,
    input  logic                   commit_ready,
    output tensor_pkg::tc_commit_t commit_data
);
    import tensor_pkg::*;

    logic                     meta_push;
    logic [`TC_WID_W-1:0]     meta_wid;
    tc_meta_t                 meta_data;
    logic [`TC_NUM_WARPS-1:0] meta_space;
    logic                     op_valid;
    logic                     op_ready;
    tc_tile_op_t              op;
    logic                     res_valid;
    logic                     res_ready;
    tc_tile_res_t             res;

    tensor_operand_decode i_decode (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_data  (issue_data),
        .meta_space  (meta_space),
        .meta_push   (meta_push),
        .meta_wid    (meta_wid),
        .meta_data   (meta_data),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .op          (op)
    );

    tensor_dpu i_dpu (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op        (op),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    tensor_commit i_commit (
        .clk          (clk),
        .reset        (reset),
        .meta_push    (meta_push),
        .meta_wid     (meta_wid),
        .meta_data    (meta_data),
        .meta_space   (meta_space),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .res          (res),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_data  (commit_data)
    );

endmodule

// File: tb/tensor_clock_gen.sv
`timescale 1ns/100ps

module tensor_clock_gen #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // reset drops on a rising edge, like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: tb/tensor_core_tb.sv
`timescale 1ns/100ps
`include "tensor_settings.svh"

module tensor_core_tb;
    import tensor_pkg::*;

    // one pair in test 1, four in tests 2 and 3, eight in test 4
    localparam int num_pairs   = 17;
    localparam int cycle_limit = 40 * num_pairs + 200;

    logic        clk;
    logic        reset;
    logic        issue_valid;
    logic        issue_ready;
    tc_issue_t   issue_data;
    logic        commit_valid;
    logic        commit_ready;
    tc_commit_t  commit_data;

    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] lfsr_state = 32'h1a9657d3;
    tc_commit_t  exp_q [$];
    tc_commit_t  got_q [$];
    int          got_cycle_q [$];

    tensor_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    tensor_octet_core i_dut (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_data   (issue_data),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_data  (commit_data)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles, results still missing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // log every commit transfer with the edge it happened on
    always @(posedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            got_q.push_back(commit_data);
            got_cycle_q.push_back(cycles);
        end
    end

    // galois form, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_word();
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003
                                       : lfsr_state >> 1;
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic tc_issue_t make_op(input int wid, input int step, input logic last,
                                          input int rd, input int tag);
        tc_issue_t op;
        op.wid          = `TC_WID_W'(wid);
        op.step         = 2'(step);
        op.last_in_pair = last;
        op.rd           = `TC_RD_W'(rd);
        op.tag          = `TC_TAG_W'(tag);
        for (int i = 0; i < `TC_LANES; i++) begin
            op.a[i] = random_word();
            op.b[i] = random_word();
            op.c[i] = random_word();
        end
        return op;
    endfunction

    // A column m sits in lanes {0,1,4,5}, moved up by two when step bit 0 is set
    function automatic int a_lane(input logic [1:0] step, input int m);
        return (m < 2 ? m : m + 2) + (step[0] ? 2 : 0);
    endfunction

    function automatic int b_lane(input logic [1:0] step, input int n);
        return n + (step[1] ? 4 : 0);
    endfunction

    // expected beats of one pair, p gives k=0 and C rows 0-1, q gives k=1 and rows 2-3
    task automatic model_pair(input tc_issue_t p, input tc_issue_t q);
        int         m;
        int         n;
        tc_commit_t beat;
        for (int bt = 0; bt < 2; bt++) begin
            beat.wid       = q.wid;
            beat.rd        = bt ? q.rd : p.rd;
            beat.tag       = bt ? q.tag : p.tag;
            beat.last_beat = bt[0];
            for (int lane = 0; lane < `TC_LANES; lane++) begin
                m = 2 * bt + lane / 4;
                n = lane % 4;
                beat.data[lane] = p.a[a_lane(p.step, m)] * p.b[b_lane(p.step, n)]
                                + q.a[a_lane(q.step, m)] * q.b[b_lane(q.step, n)]
                                + (bt ? q.c[lane] : p.c[lane]);
            end
            exp_q.push_back(beat);
        end
    endtask

    task automatic compare_commit(input tc_commit_t got, input tc_commit_t exp,
                                  input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, commit beat differs", $time, what);
            $display("    got  wid %0d rd %0d tag %h last %b data %h",
                     got.wid, got.rd, got.tag, got.last_beat, got.data);
            $display("    want wid %0d rd %0d tag %h last %b data %h",
                     exp.wid, exp.rd, exp.tag, exp.last_beat, exp.data);
        end
    endtask

    task automatic compare_ready(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // called at a rising edge, returns at the edge of acceptance
    task automatic send_op(input tc_issue_t op, output int acc_cycle);
        issue_valid <= 1'b1;
        issue_data  <= op;
        do begin
            @(posedge clk);
        end while (!issue_ready);
        acc_cycle = cycles;
    endtask

    task automatic wait_beats(input int n);
        while (got_q.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        int n;
        n = exp_q.size();
        wait_beats(n);
        // a few idle cycles so that any extra beat shows up in the count
        repeat (4) @(posedge clk);
        compare_count(got_q.size(), n, {name, " beat count"});
        for (int i = 0; i < n && i < got_q.size(); i++) begin
            compare_commit(got_q[i], exp_q[i], name);
        end
        exp_q.delete();
        got_q.delete();
        got_cycle_q.delete();
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    task automatic test_after_reset();
        int err_before;
        err_before = errors;
        repeat (5) begin
            @(posedge clk);
            compare_ready(commit_valid, 1'b0, "commit_valid after reset");
            compare_ready(issue_ready, 1'b1, "issue_ready after reset");
        end
        finish_test("after_reset", err_before);
    endtask

    task automatic test_single_pair();
        tc_issue_t p;
        tc_issue_t q;
        int        acc_first;
        int        acc_second;
        int        err_before;
        err_before = errors;
        p = make_op(0, 0, 1'b0, 3, 8'h11);
        q = make_op(0, 3, 1'b1, 4, 8'h12);
        model_pair(p, q);
        send_op(p, acc_first);
        send_op(q, acc_second);
        issue_valid <= 1'b0;
        wait_beats(2);
        compare_count(got_cycle_q[0] - acc_second, `TC_DPU_LATENCY + 1, "beat 0 latency");
        finish_test("single_pair", err_before);
    endtask

    task automatic test_step_combos();
        tc_issue_t p;
        tc_issue_t q;
        int        acc;
        int        err_before;
        err_before = errors;
        for (int s = 0; s < 4; s++) begin
            p = make_op(1, s, 1'b0, 2 * s, 8'h20 + 2 * s);
            q = make_op(1, 3 - s, 1'b1, 2 * s + 1, 8'h21 + 2 * s);
            model_pair(p, q);
            send_op(p, acc);
            send_op(q, acc);
        end
        issue_valid <= 1'b0;
        finish_test("step_combos", err_before);
    endtask

    task automatic test_interleaved();
        tc_issue_t first [4];
        tc_issue_t second;
        int        order [4];
        int        w;
        int        acc;
        int        err_before;
        err_before = errors;
        order = '{2, 0, 3, 1};
        for (int i = 0; i < 4; i++) begin
            first[i] = make_op(i, i, 1'b0, 8 + i, 8'h40 + i);
            send_op(first[i], acc);
        end
        // tiles commit in the order of the second operations
        for (int i = 0; i < 4; i++) begin
            w = order[i];
            second = make_op(w, 3 - w, 1'b1, 16 + w, 8'h50 + w);
            model_pair(first[w], second);
            send_op(second, acc);
        end
        issue_valid <= 1'b0;
        finish_test("interleaved", err_before);
    endtask

    task automatic test_backpressure();
        tc_issue_t p;
        tc_issue_t q;
        int        acc;
        logic      stall_seen;
        logic      sent_all;
        int        err_before;
        err_before = errors;
        stall_seen = 1'b0;
        sent_all   = 1'b0;
        commit_ready <= 1'b0;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    p = make_op(i % 4, i % 4, 1'b0, i, 8'h80 + 2 * i);
                    q = make_op(i % 4, 3 - i % 4, 1'b1, 16 + i, 8'h81 + 2 * i);
                    model_pair(p, q);
                    send_op(p, acc);
                    send_op(q, acc);
                end
                issue_valid <= 1'b0;
                sent_all = 1'b1;
            end
            begin
                while (!stall_seen && !sent_all) begin
                    @(posedge clk);
                    if (issue_valid && !issue_ready) begin
                        stall_seen = 1'b1;
                    end
                end
                // hold the stall a little before the commit side opens up
                repeat (8) @(posedge clk);
                commit_ready <= 1'b1;
            end
        join
        compare_ready(stall_seen, 1'b1, "issue stall under commit back-pressure");
        finish_test("backpressure", err_before);
    endtask

    initial begin
        issue_valid  = 1'b0;
        issue_data   = '0;
        commit_ready = 1'b0;
        do begin
            @(posedge clk);
        end while (reset);

        test_after_reset();
        commit_ready <= 1'b1;
        test_single_pair();
        test_step_combos();
        test_interleaved();
        test_backpressure();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
hdl/tensor_pkg.sv
hdl/tensor_fifo.sv
hdl/tensor_operand_decode.sv
hdl/tensor_dpu.sv
hdl/tensor_commit.sv
hdl/tensor_octet_core.sv
tb/tensor_clock_gen.sv
tb/tensor_core_tb.sv

// File: Bender.yml
package:
  name: tensor_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/tensor_pkg.sv
      - hdl/tensor_fifo.sv
      - hdl/tensor_operand_decode.sv
      - hdl/tensor_dpu.sv
      - hdl/tensor_commit.sv
      - hdl/tensor_octet_core.sv
      - target: test
        files:
          - tb/tensor_clock_gen.sv
          - tb/tensor_core_tb.sv
